// ==== all.f ====
hw/ipod_pkg.sv
hw/player_control.sv
hw/sample_tick_gen.sv
hw/flash_reader.sv
hw/sample_port.sv
hw/ipod_top.sv
dv/flash_model.sv
dv/tb_ipod_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= tb_ipod_top
RTL_TOP   ?= ipod_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
RTL_SRCS  ?= $(filter hw/%.sv,$(shell cat $(FILELIST)))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(VFLAGS) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --top-module $(TB_TOP) $(VFLAGS) -f $(FILELIST)

build:
	$(VERILATOR) --binary --timing --top-module $(TB_TOP) -Mdir $(OBJ_DIR) $(VFLAGS) -f $(FILELIST)

sim: build
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^TEST PASS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_ipod_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_ipod_top
  import ipod_pkg::*;
();

  localparam int def_period = 40;
  localparam int step       = 4;
  localparam int min_period = 24;
  localparam int max_period = 56;
  localparam int words      = 16;

  logic          CLK_50M;
  logic          speed_reset_event;
  logic          cmd_req;
  ascii_t        cmd_code;
  logic          cmd_ack;
  logic          speed_up;
  logic          speed_down;
  period_t       sample_period;
  logic          flash_read;
  flash_addr_t   flash_addr;
  logic          flash_waitrequest;
  flash_word_t   flash_readdata;
  logic          flash_readdatavalid;
  logic          sample_req;
  audio_sample_t sample_data;
  logic          sample_ack;

  int      errors;
  int      checks;
  int      tests;
  int      errors_at_start;
  // Reference model of the sample stream
  int      m_addr;
  logic    m_valid;
  logic    m_low_pending;
  logic    m_forward;
  period_t exp_period;

  ipod_top #(
    .sample_period_default(def_period),
    .period_step          (step),
    .period_min           (min_period),
    .period_max           (max_period),
    .flash_words          (words)
  ) u_dut (
    .CLK_50M            (CLK_50M),
    .speed_reset_event  (speed_reset_event),
    .cmd_req            (cmd_req),
    .cmd_code           (cmd_code),
    .cmd_ack            (cmd_ack),
    .speed_up           (speed_up),
    .speed_down         (speed_down),
    .sample_period      (sample_period),
    .flash_read         (flash_read),
    .flash_addr         (flash_addr),
    .flash_waitrequest  (flash_waitrequest),
    .flash_readdata     (flash_readdata),
    .flash_readdatavalid(flash_readdatavalid),
    .sample_req         (sample_req),
    .sample_data        (sample_data),
    .sample_ack         (sample_ack)
  );

  flash_model u_flash (
    .CLK_50M            (CLK_50M),
    .flash_read         (flash_read),
    .flash_addr         (flash_addr),
    .flash_waitrequest  (flash_waitrequest),
    .flash_readdata     (flash_readdata),
    .flash_readdatavalid(flash_readdatavalid)
  );

  always #10 CLK_50M = ~CLK_50M;

  // ====================
  // Checks and reporting
  // ====================

  task automatic check_sample(input audio_sample_t got, input audio_sample_t exp,
                              input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_period(input period_t got, input period_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timed out at %0t waiting for %s", $time, what);
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("%s done with %0d errors", name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  // ====================
  // Stream reference
  // ====================

  task automatic reset_model();
    m_addr        = 0;
    m_valid       = 1'b0;
    m_low_pending = 1'b0;
    m_forward     = 1'b1;
    exp_period    = period_t'(def_period);
  endtask

  // Lower byte of the held word comes before a new fetch
  task automatic predict_sample(output audio_sample_t s);
    if (m_low_pending)
    begin
      s             = audio_sample_t'(~m_addr[7:0]);
      m_low_pending = 1'b0;
    end
    else
    begin
      if (!m_valid)
        m_addr = 0;
      else if (m_forward)
        m_addr = (m_addr == words - 1) ? 0 : m_addr + 1;
      else
        m_addr = (m_addr == 0) ? words - 1 : m_addr - 1;
      m_valid       = 1'b1;
      m_low_pending = 1'b1;
      s             = audio_sample_t'(m_addr[7:0]);
    end
  endtask

  // ====================
  // Bus helpers
  // ====================

  task automatic apply_reset();
    @(negedge CLK_50M);
    speed_reset_event = 1'b1;
    repeat (10) @(negedge CLK_50M);
    speed_reset_event = 1'b0;
    reset_model();
  endtask

  task automatic send_command(input ascii_t code);
    int n;
    @(negedge CLK_50M);
    cmd_code = code;
    cmd_req  = 1'b1;
    n = 0;
    while (!cmd_ack && n < 20)
    begin
      @(negedge CLK_50M);
      n++;
    end
    if (!cmd_ack)
      report_timeout("cmd_ack to rise");
    cmd_req = 1'b0;
    n = 0;
    while (cmd_ack && n < 20)
    begin
      @(negedge CLK_50M);
      n++;
    end
    if (cmd_ack)
      report_timeout("cmd_ack to fall");
    // Track direction in the model
    if (code == cmd_forward)
      m_forward = 1'b1;
    else if (code == cmd_backward)
      m_forward = 1'b0;
  endtask

  task automatic pulse_speed(input logic faster);
    int e;
    @(negedge CLK_50M);
    speed_up   = faster;
    speed_down = !faster;
    @(negedge CLK_50M);
    speed_up   = 1'b0;
    speed_down = 1'b0;
    e = faster ? int'(exp_period) - step : int'(exp_period) + step;
    if (e < min_period)
      e = min_period;
    if (e > max_period)
      e = max_period;
    exp_period = period_t'(e);
    check_period(sample_period, exp_period, "sample_period after speed pulse");
  endtask

  task automatic wait_sample_req(output audio_sample_t s);
    int n;
    n = 0;
    while (!sample_req && n < 1000)
    begin
      @(negedge CLK_50M);
      n++;
    end
    if (!sample_req)
      report_timeout("sample_req to rise");
    s = sample_data;
  endtask

  task automatic release_sample(input int ack_delay);
    int n;
    repeat (ack_delay) @(negedge CLK_50M);
    sample_ack = 1'b1;
    n = 0;
    while (sample_req && n < 20)
    begin
      @(negedge CLK_50M);
      n++;
    end
    if (sample_req)
      report_timeout("sample_req to fall");
    sample_ack = 1'b0;
  endtask

  task automatic collect_sample(input int ack_delay);
    audio_sample_t got;
    audio_sample_t exp;
    wait_sample_req(got);
    predict_sample(exp);
    check_sample(got, exp, "stream sample");
    release_sample(ack_delay);
  endtask

  task automatic expect_quiet(input int cycles);
    logic seen;
    seen = 1'b0;
    repeat (cycles)
    begin
      @(negedge CLK_50M);
      if (sample_req)
        seen = 1'b1;
    end
    checks++;
    if (seen)
    begin
      errors++;
      $display("FAILED at %0t: sample_req rose while paused", $time);
    end
  endtask

  // ====================
  // Directed tests
  // ====================

  task automatic reset_and_idle();
    check_period(sample_period, period_t'(def_period), "sample_period after reset");
    expect_quiet(50 * def_period);
    send_command(cmd_pause);
    report_test("reset_and_idle");
  endtask

  task automatic forward_play();
    send_command(cmd_play);
    repeat (40) collect_sample(0);
    report_test("forward_play");
  endtask

  // Pause while a sample is held so the lower byte stays pending
  task automatic pause_and_reverse();
    audio_sample_t got;
    audio_sample_t exp;
    wait_sample_req(got);
    send_command(cmd_pause);
    predict_sample(exp);
    check_sample(got, exp, "sample before pause");
    release_sample(0);
    expect_quiet(20 * def_period);
    send_command(cmd_backward);
    send_command(cmd_play);
    repeat (16) collect_sample(0);
    report_test("pause_and_reverse");
  endtask

  task automatic speed_limits();
    repeat (5) pulse_speed(1'b1);
    repeat (10) pulse_speed(1'b0);
    apply_reset();
    check_period(sample_period, period_t'(def_period), "sample_period after reset");
    report_test("speed_limits");
  endtask

  task automatic slow_sink();
    send_command(cmd_play);
    repeat (20) collect_sample(200);
    report_test("slow_sink");
  endtask

  task automatic unknown_command();
    send_command(8'h5A);
    check_period(sample_period, exp_period, "sample_period after unknown code");
    repeat (6) collect_sample(0);
    report_test("unknown_command");
  endtask

  initial
  begin
    CLK_50M           = 1'b0;
    speed_reset_event = 1'b1;
    cmd_req           = 1'b0;
    cmd_code          = '0;
    speed_up          = 1'b0;
    speed_down        = 1'b0;
    sample_ack        = 1'b0;
    errors            = 0;
    checks            = 0;
    tests             = 0;
    errors_at_start   = 0;
    reset_model();
    apply_reset();
    reset_and_idle();
    forward_play();
    pause_and_reverse();
    speed_limits();
    slow_sink();
    unknown_command();
    $display("Tests run %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/flash_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module flash_model
  import ipod_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        flash_read,
  input  flash_addr_t flash_addr,
  output logic        flash_waitrequest,
  output flash_word_t flash_readdata,
  output logic        flash_readdatavalid
);

  logic [31:0] lfsr;
  logic        lat_lo;
  logic        lat_hi;
  int unsigned latency;
  flash_addr_t held_addr;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Upper byte holds the address and bits 15:8 its inverse
  function automatic flash_word_t word_at(input flash_addr_t a);
    return {a[7:0], 8'h00, ~a[7:0], 8'h00};
  endfunction

  initial
  begin
    lfsr                = 32'h417c;
    latency             = 0;
    held_addr           = '0;
    flash_waitrequest   = 1'b1;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
  end

  always @(negedge CLK_50M)
  begin
    flash_readdatavalid = 1'b0;
    if (latency != 0)
    begin
      latency = latency - 1;
      if (latency == 0)
      begin
        flash_readdatavalid = 1'b1;
        flash_readdata      = word_at(held_addr);
      end
    end
    // Busy while a read is outstanding
    if (latency != 0)
      flash_waitrequest = 1'b1;
    else
    begin
      lfsr              = lfsr_step(lfsr);
      flash_waitrequest = lfsr[0];
    end
    if (flash_read && !flash_waitrequest)
    begin
      held_addr = flash_addr;
      lfsr      = lfsr_step(lfsr);
      lat_lo    = lfsr[0];
      lfsr      = lfsr_step(lfsr);
      lat_hi    = lfsr[0];
      latency   = 32'd1 + {30'd0, lat_hi, lat_lo};
    end
  end

endmodule

`default_nettype wire

// ==== hw/ipod_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ipod_top
  import ipod_pkg::*;
#(
  parameter int unsigned sample_period_default = 1136,
  parameter int unsigned period_step           = 1,
  parameter int unsigned period_min            = 16,
  parameter int unsigned period_max            = 4000,
  parameter int unsigned flash_words           = 2 ** flash_addr_w
)
(
  input  logic          CLK_50M,
  input  logic          speed_reset_event,
  // Keyboard command handshake
  input  logic          cmd_req,
  input  ascii_t        cmd_code,
  output logic          cmd_ack,
  input  logic          speed_up,
  input  logic          speed_down,
  output period_t       sample_period,
  // Flash read port
  output logic          flash_read,
  output flash_addr_t   flash_addr,
  input  logic          flash_waitrequest,
  input  flash_word_t   flash_readdata,
  input  logic          flash_readdatavalid,
  // Sample output handshake
  output logic          sample_req,
  output audio_sample_t sample_data,
  input  logic          sample_ack
);

  logic          play;
  logic          forward;
  logic          sample_tick;
  logic          out_valid;
  logic          out_busy;
  audio_sample_t out_sample;

  player_control #(
    .sample_period_default(sample_period_default),
    .period_step          (period_step),
    .period_min           (period_min),
    .period_max           (period_max)
  ) u_player_control (
    .CLK_50M          (CLK_50M),
    .speed_reset_event(speed_reset_event),
    .cmd_req          (cmd_req),
    .cmd_code         (cmd_code),
    .speed_up         (speed_up),
    .speed_down       (speed_down),
    .cmd_ack          (cmd_ack),
    .play             (play),
    .forward          (forward),
    .sample_period    (sample_period)
  );

  sample_tick_gen u_sample_tick_gen (
    .CLK_50M          (CLK_50M),
    .speed_reset_event(speed_reset_event),
    .sample_period    (sample_period),
    .sample_tick      (sample_tick)
  );

  flash_reader #(
    .flash_words(flash_words)
  ) u_flash_reader (
    .CLK_50M            (CLK_50M),
    .speed_reset_event  (speed_reset_event),
    .sample_tick        (sample_tick),
    .play               (play),
    .forward            (forward),
    .flash_waitrequest  (flash_waitrequest),
    .flash_readdata     (flash_readdata),
    .flash_readdatavalid(flash_readdatavalid),
    .out_busy           (out_busy),
    .flash_read         (flash_read),
    .flash_addr         (flash_addr),
    .out_valid          (out_valid),
    .out_sample         (out_sample)
  );

  sample_port u_sample_port (
    .CLK_50M          (CLK_50M),
    .speed_reset_event(speed_reset_event),
    .out_valid        (out_valid),
    .out_sample       (out_sample),
    .sample_ack       (sample_ack),
    .out_busy         (out_busy),
    .sample_req       (sample_req),
    .sample_data      (sample_data)
  );

endmodule

`default_nettype wire

// ==== hw/sample_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_port
  import ipod_pkg::*;
(
  input  logic          CLK_50M,
  input  logic          speed_reset_event,
  input  logic          out_valid,
  input  audio_sample_t out_sample,
  input  logic          sample_ack,
  output logic          out_busy,
  output logic          sample_req,
  output audio_sample_t sample_data
);

  typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_release
  } state_t;

  state_t state;

  // Four-phase initiator towards the codec side
  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
      state <= st_idle;
    else
    begin
      case (state)
        st_idle:
          if (out_valid)
            state <= st_req;
        st_req:
          if (sample_ack)
            state <= st_release;
        // Wait for the sink to drop its ack
        st_release:
          if (!sample_ack)
            state <= st_idle;
        default:
          state <= st_idle;
      endcase
    end
  end

  // Sample is held stable for the whole handshake
  always_ff @(posedge CLK_50M)
  begin
    if (state == st_idle && out_valid)
      sample_data <= out_sample;
  end

  assign sample_req = (state == st_req);
  assign out_busy   = (state != st_idle);

endmodule

`default_nettype wire

// ==== hw/flash_reader.sv ====
`timescale 1ns/1ns
`default_nettype none

module flash_reader
  import ipod_pkg::*;
#(
  parameter int unsigned flash_words = 2 ** flash_addr_w
)
(
  input  logic          CLK_50M,
  input  logic          speed_reset_event,
  input  logic          sample_tick,
  input  logic          play,
  input  logic          forward,
  input  logic          flash_waitrequest,
  input  flash_word_t   flash_readdata,
  input  logic          flash_readdatavalid,
  input  logic          out_busy,
  output logic          flash_read,
  output flash_addr_t   flash_addr,
  output logic          out_valid,
  output audio_sample_t out_sample
);

  localparam flash_addr_t last_word = flash_addr_t'(flash_words - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait_data,
    st_emit
  } state_t;

  state_t        state;
  logic          addr_valid;
  logic          low_pending;
  audio_sample_t low_byte;
  flash_addr_t   next_addr;
  logic          take_tick;

  // ====================
  // Address walker
  // ====================

  // Step from the last word read, wrapping at both ends
  always_comb
  begin
    if (!addr_valid)
      next_addr = '0;
    else if (forward)
      next_addr = (flash_addr == last_word) ? '0 : flash_addr + flash_addr_t'(1);
    else
      next_addr = (flash_addr == '0) ? last_word : flash_addr - flash_addr_t'(1);
  end

  // Ticks outside idle or under back-pressure are lost
  assign take_tick = sample_tick && play && !out_busy;

  // ====================
  // Read engine
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
    begin
      state       <= st_idle;
      addr_valid  <= 1'b0;
      low_pending <= 1'b0;
      flash_addr  <= '0;
    end
    else
    begin
      case (state)
        st_idle:
          if (take_tick)
          begin
            if (low_pending)
            begin
              // Second half of the held word, no flash access
              low_pending <= 1'b0;
              state       <= st_emit;
            end
            else
            begin
              flash_addr <= next_addr;
              addr_valid <= 1'b1;
              state      <= st_request;
            end
          end
        st_request:
          if (!flash_waitrequest)
            state <= st_wait_data;
        st_wait_data:
          if (flash_readdatavalid)
          begin
            low_pending <= 1'b1;
            state       <= st_emit;
          end
        st_emit:
          state <= st_idle;
        default:
          state <= st_idle;
      endcase
    end
  end

  // Upper byte goes out first, lower byte is kept for the next tick
  always_ff @(posedge CLK_50M)
  begin
    if (state == st_idle && take_tick && low_pending)
      out_sample <= low_byte;
    else if (state == st_wait_data && flash_readdatavalid)
    begin
      out_sample <= audio_sample_t'(flash_readdata[31:24]);
      low_byte   <= audio_sample_t'(flash_readdata[15:8]);
    end
  end

  assign flash_read = (state == st_request);
  assign out_valid  = (state == st_emit);

endmodule

`default_nettype wire

// ==== hw/sample_tick_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_tick_gen
  import ipod_pkg::*;
(
  input  logic    CLK_50M,
  input  logic    speed_reset_event,
  input  period_t sample_period,
  output logic    sample_tick
);

  period_t count;

  // Down-counter, reloads at zero so the tick repeats every sample_period cycles
  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
    begin
      count       <= '0;
      sample_tick <= 1'b0;
    end
    else if (count == '0)
    begin
      // New period only takes effect here
      count       <= sample_period - period_t'(1);
      sample_tick <= 1'b1;
    end
    else
    begin
      count       <= count - period_t'(1);
      sample_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/player_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module player_control
  import ipod_pkg::*;
#(
  parameter int unsigned sample_period_default = 1136,
  parameter int unsigned period_step           = 1,
  parameter int unsigned period_min            = 16,
  parameter int unsigned period_max            = 4000
)
(
  input  logic    CLK_50M,
  input  logic    speed_reset_event,
  input  logic    cmd_req,
  input  ascii_t  cmd_code,
  input  logic    speed_up,
  input  logic    speed_down,
  output logic    cmd_ack,
  output logic    play,
  output logic    forward,
  output period_t sample_period
);

  localparam period_t period_default_p = period_t'(sample_period_default);
  localparam period_t step_p           = period_t'(period_step);
  localparam period_t min_p            = period_t'(period_min);
  localparam period_t max_p            = period_t'(period_max);

  // ====================
  // Command handshake
  // ====================

  // Decode only on the rising step of the handshake
  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
    begin
      cmd_ack <= 1'b0;
      play    <= 1'b0;
      forward <= 1'b1;
    end
    else
    begin
      cmd_ack <= cmd_req;
      if (cmd_req && !cmd_ack)
      begin
        case (cmd_code)
          cmd_play:     play    <= 1'b1;
          cmd_pause:    play    <= 1'b0;
          cmd_forward:  forward <= 1'b1;
          cmd_backward: forward <= 1'b0;
          // Anything else is acknowledged and dropped
          default:      ;
        endcase
      end
    end
  end

  // ====================
  // Sample period
  // ====================

  // Shorter period plays faster; clamp at both limits
  always_ff @(posedge CLK_50M)
  begin
    if (speed_reset_event)
      sample_period <= period_default_p;
    else if (speed_up && !speed_down)
    begin
      if (sample_period > min_p)
        sample_period <= (sample_period - min_p >= step_p) ? sample_period - step_p : min_p;
    end
    else if (speed_down && !speed_up)
    begin
      if (sample_period < max_p)
        sample_period <= (max_p - sample_period >= step_p) ? sample_period + step_p : max_p;
    end
  end

endmodule

`default_nettype wire

// ==== hw/ipod_pkg.sv ====
`default_nettype none

package ipod_pkg;

  // ====================
  // Flash geometry
  // ====================

  // Word address width of the flash
  localparam int flash_addr_w = 23;

  typedef logic [flash_addr_w-1:0] flash_addr_t;
  typedef logic [31:0]             flash_word_t;

  // ====================
  // Audio and control
  // ====================

  typedef logic signed [7:0] audio_sample_t;
  typedef logic [7:0]        ascii_t;

  // Sample period in CLK_50M cycles
  typedef logic [15:0] period_t;

  // Keyboard commands, upper case ASCII
  localparam ascii_t cmd_play     = 8'h45;  // E
  localparam ascii_t cmd_pause    = 8'h44;  // D
  localparam ascii_t cmd_forward  = 8'h46;  // F
  localparam ascii_t cmd_backward = 8'h42;  // B

endpackage

`default_nettype wire
